// File: bench/tb_axi_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         aw_valid,
    output logic                         aw_ready,
    input  logic [cache_pkg::addr_w-1:0] aw_addr,
    input  logic                         w_valid,
    output logic                         w_ready,
    input  logic [cache_pkg::data_w-1:0] w_data,
    output logic                         b_valid,
    input  logic                         b_ready,
    input  logic                         ar_valid,
    output logic                         ar_ready,
    input  logic [cache_pkg::addr_w-1:0] ar_addr,
    output logic                         r_valid,
    input  logic                         r_ready,
    output logic [cache_pkg::data_w-1:0] r_data
);

    // only written words live here, everything else follows the address rule
    logic [31:0] words [logic [31:0]];
    logic [31:0] log_addr [16];
    logic [31:0] log_data [16];
    int          log_count = 0;

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic stall();
        repeat ($urandom_range(3, 0)) tick();
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        void'($urandom(32'h201e9339));
        forever begin
            tick();
            if (reset && aw_valid) begin
                stall();
                aw_ready = 1'b1;
                addr = aw_addr;
                tick();
                aw_ready = 1'b0;
                while (!w_valid) tick();
                stall();
                w_ready = 1'b1;
                data = w_data;
                tick();
                w_ready = 1'b0;
                words[addr] = data;
                if (log_count < 16) begin
                    log_addr[log_count] = addr;
                    log_data[log_count] = data;
                    log_count++;
                end
                stall();
                b_valid = 1'b1;
                while (!b_ready) tick();
                tick();
                b_valid = 1'b0;
            end else if (reset && ar_valid) begin
                stall();
                ar_ready = 1'b1;
                addr = ar_addr;
                tick();
                ar_ready = 1'b0;
                stall();
                r_valid = 1'b1;
                r_data = words.exists(addr) ? words[addr] : (addr ^ 32'h5a5a_0000);
                while (!r_ready) tick();
                tick();
                r_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held low for 8 rising edges, released just after the last one
    initial begin
        reset = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top;

    // about 10 accesses of under 40 cycles each plus reset, with a wide margin
    localparam int max_cycles = 2000;

    // a and b share index 4, c and d share index 9
    localparam logic [31:0] addr_a = 32'h0000_1010;
    localparam logic [31:0] addr_b = 32'h0000_2010;
    localparam logic [31:0] addr_c = 32'h0000_3024;
    localparam logic [31:0] addr_d = 32'h0000_4024;

    logic                         clk;
    logic                         reset;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [cache_pkg::addr_w-1:0] wb_adr;
    logic [cache_pkg::data_w-1:0] wb_dat_w;
    logic [cache_pkg::sel_w-1:0]  wb_sel;
    logic [cache_pkg::data_w-1:0] wb_dat_r;
    logic                         wb_ack;
    logic                         aw_valid;
    logic                         aw_ready;
    logic [cache_pkg::addr_w-1:0] aw_addr;
    logic                         w_valid;
    logic                         w_ready;
    logic [cache_pkg::data_w-1:0] w_data;
    logic                         b_valid;
    logic                         b_ready;
    logic                         ar_valid;
    logic                         ar_ready;
    logic [cache_pkg::addr_w-1:0] ar_addr;
    logic                         r_valid;
    logic                         r_ready;
    logic [cache_pkg::data_w-1:0] r_data;

    logic [31:0] ref_mem [logic [31:0]];
    logic [31:0] last_ar_addr = '0;
    logic        started = 1'b0;
    logic        hit_only = 1'b0;
    int          errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle = 0;
    int          ar_count = 0;
    int          aw_cycle = 0;
    int          ar_cycle = 0;

    tb_clock u_clock (.clk(clk), .reset(reset));

    cache_top u_cache_top (.*);

    tb_axi_mem u_axi_mem (.*);

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            ar_count     <= ar_count + 1;
            last_ar_addr <= ar_addr;
            ar_cycle     <= cycle;
        end
        if (aw_valid && aw_ready) begin
            aw_cycle <= cycle;
        end
    end

    a_quiet_until_request: assert property (@(posedge clk)
        !started |-> !(aw_valid || w_valid || b_ready || ar_valid || r_ready || wb_ack))
        else begin
            errors++;
            $display("%0t: bus activity before the first request", $time);
        end

    a_no_axi_on_hit: assert property (@(posedge clk)
        hit_only |-> !ar_valid && !aw_valid)
        else begin
            errors++;
            $display("%0t: axi request seen during a cache hit", $time);
        end

    a_w_after_aw: assert property (@(posedge clk) disable iff (!reset)
        $rose(w_valid) |-> $past(aw_valid && aw_ready))
        else begin
            errors++;
            $display("%0t: write data offered before the write address completed", $time);
        end

    a_w_hold: assert property (@(posedge clk) disable iff (!reset)
        w_valid && !w_ready |=> w_valid && $stable(w_data))
        else begin
            errors++;
            $display("%0t: write data dropped or changed while stalled", $time);
        end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    function automatic logic [31:0] expect_word(input logic [31:0] adr);
        if (ref_mem.exists(adr)) begin
            return ref_mem[adr];
        end
        return adr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] apply_sel(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (new_w & mask) | (old_w & ~mask);
    endfunction

    // one classic cycle; cycles counts edges from the request to the ack
    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel,
                              output logic [31:0] rdat, output int cycles);
        started  = 1'b1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        tick();
        cycles = 1;
        while (!wb_ack) begin
            tick();
            cycles++;
        end
        rdat = wb_dat_r;
        if (we) begin
            ref_mem[adr] = apply_sel(expect_word(adr), dat, sel);
        end
        tick();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        int          lat;
        int          t_err;
        int          ar_before;
        int          log_before;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        wait (reset === 1'b1);
        tick();

        t_err = errors;
        repeat (4) tick();
        end_test("reset", t_err);

        t_err = errors;
        ar_before = ar_count;
        bus_access(1'b0, addr_a, 32'h0, 4'h0, rd, lat);
        check_value("wb_dat_r", rd, expect_word(addr_a));
        check_value("ar handshakes", ar_count - ar_before, 1);
        check_value("ar_addr", last_ar_addr, addr_a);
        end_test("read miss", t_err);

        t_err = errors;
        hit_only = 1'b1;
        bus_access(1'b0, addr_a, 32'h0, 4'h0, rd, lat);
        check_value("hit latency", lat, 2);
        check_value("wb_dat_r", rd, expect_word(addr_a));
        hit_only = 1'b0;
        end_test("read hit", t_err);

        t_err = errors;
        hit_only = 1'b1;
        bus_access(1'b1, addr_a, 32'hdead_beef, 4'b0101, rd, lat);
        check_value("hit latency", lat, 2);
        bus_access(1'b0, addr_a, 32'h0, 4'h0, rd, lat);
        check_value("wb_dat_r", rd, expect_word(addr_a));
        hit_only = 1'b0;
        end_test("write hit", t_err);

        // dirty line at index 4 goes out before the refill
        t_err = errors;
        ar_before = ar_count;
        log_before = u_axi_mem.log_count;
        bus_access(1'b0, addr_b, 32'h0, 4'h0, rd, lat);
        check_value("write log entries", u_axi_mem.log_count - log_before, 1);
        check_value("aw_addr", u_axi_mem.log_addr[log_before], addr_a);
        check_value("w_data", u_axi_mem.log_data[log_before], expect_word(addr_a));
        check_value("ar handshakes", ar_count - ar_before, 1);
        check_value("ar_addr", last_ar_addr, addr_b);
        check_value("wb_dat_r", rd, expect_word(addr_b));
        assert (aw_cycle < ar_cycle) else begin
            errors++;
            $display("%0t: write-back did not come before the refill read", $time);
        end
        end_test("dirty eviction", t_err);

        t_err = errors;
        log_before = u_axi_mem.log_count;
        bus_access(1'b1, addr_c, 32'h1234_5678, 4'b1100, rd, lat);
        check_value("write log entries", u_axi_mem.log_count - log_before, 0);
        bus_access(1'b0, addr_c, 32'h0, 4'h0, rd, lat);
        check_value("hit latency", lat, 2);
        check_value("wb_dat_r", rd, expect_word(addr_c));
        bus_access(1'b0, addr_d, 32'h0, 4'h0, rd, lat);
        check_value("write log entries", u_axi_mem.log_count - log_before, 1);
        check_value("aw_addr", u_axi_mem.log_addr[log_before], addr_c);
        check_value("w_data", u_axi_mem.log_data[log_before], expect_word(addr_c));
        check_value("wb_dat_r", rd, expect_word(addr_d));
        end_test("write miss", t_err);

        repeat (4) tick();
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (errors == 0 && fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cache/cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
    input  logic                          clk,
    input  logic                          reset,

    // wishbone classic slave
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [cache_pkg::addr_w-1:0]  wb_adr,
    input  logic [cache_pkg::data_w-1:0]  wb_dat_w,
    input  logic [cache_pkg::sel_w-1:0]   wb_sel,
    output logic [cache_pkg::data_w-1:0]  wb_dat_r,
    output logic                          wb_ack,

    // memory requests
    mem_req_if.ctrl                       mem,

    // store
    output logic [cache_pkg::index_w-1:0] index,
    output logic                          wr_en,
    output logic [cache_pkg::tag_w-1:0]   wr_tag,
    output logic [cache_pkg::data_w-1:0]  wr_data,
    output logic                          wr_dirty,
    input  logic                          rd_valid,
    input  logic                          rd_dirty,
    input  logic [cache_pkg::tag_w-1:0]   rd_tag,
    input  logic [cache_pkg::data_w-1:0]  rd_data
);

    cache_pkg::ctrl_state_t state, next_state;

    logic [cache_pkg::tag_w-1:0]  adr_tag;
    logic                         hit;
    logic [cache_pkg::data_w-1:0] hit_word;
    logic [cache_pkg::data_w-1:0] fill_word;
    logic [cache_pkg::data_w-1:0] resp_data;

    function automatic logic [cache_pkg::data_w-1:0] merge_bytes(
        input logic [cache_pkg::data_w-1:0] old_word,
        input logic [cache_pkg::data_w-1:0] new_word,
        input logic [cache_pkg::sel_w-1:0]  sel
    );
        logic [cache_pkg::data_w-1:0] result;
        result = old_word;
        for (int b = 0; b < cache_pkg::sel_w; b++) begin
            if (sel[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign index   = wb_adr[cache_pkg::index_lo +: cache_pkg::index_w];
    assign adr_tag = wb_adr[cache_pkg::tag_lo +: cache_pkg::tag_w];
    assign hit     = rd_valid && (rd_tag == adr_tag);

    assign hit_word  = wb_we ? merge_bytes(rd_data, wb_dat_w, wb_sel) : rd_data;
    assign fill_word = wb_we ? merge_bytes(mem.rdata, wb_dat_w, wb_sel) : mem.rdata;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= cache_pkg::c_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::c_idle: begin
                if (wb_cyc && wb_stb) begin
                    next_state = cache_pkg::c_lookup;
                end
            end
            cache_pkg::c_lookup: begin
                if (hit) begin
                    next_state = cache_pkg::c_ack;
                end else if (rd_valid && rd_dirty) begin
                    next_state = cache_pkg::c_evict;
                end else begin
                    next_state = cache_pkg::c_refill;
                end
            end
            cache_pkg::c_evict: begin
                if (mem.axi_ready) begin
                    next_state = cache_pkg::c_refill;
                end
            end
            cache_pkg::c_refill: begin
                if (mem.axi_ready) begin
                    next_state = cache_pkg::c_ack;
                end
            end
            cache_pkg::c_ack: begin
                next_state = cache_pkg::c_idle;
            end
            default: begin
                next_state = cache_pkg::c_idle;
            end
        endcase
    end

    // store writes: write hit in lookup, refill word on the read return
    always_comb begin
        wr_en    = 1'b0;
        wr_tag   = adr_tag;
        wr_dirty = wb_we;
        wr_data  = hit_word;
        if (state == cache_pkg::c_lookup && hit && wb_we) begin
            wr_en = 1'b1;
        end else if (state == cache_pkg::c_refill && mem.axi_ready) begin
            wr_en   = 1'b1;
            wr_data = fill_word;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::c_lookup && hit) begin
            resp_data <= hit_word;
        end else if (state == cache_pkg::c_refill && mem.axi_ready) begin
            resp_data <= fill_word;
        end
    end

    // victim line goes out from the store outputs, which hold during evict
    assign mem.start_write = (state == cache_pkg::c_evict);
    assign mem.start_read  = (state == cache_pkg::c_refill);
    assign mem.addr  = (state == cache_pkg::c_evict) ?
                       {rd_tag, index, {cache_pkg::off_w{1'b0}}} :
                       {adr_tag, index, {cache_pkg::off_w{1'b0}}};
    assign mem.wdata = rd_data;

    assign wb_ack   = (state == cache_pkg::c_ack);
    assign wb_dat_r = resp_data;

    a_one_start: assert property (@(posedge clk) disable iff (!reset)
        !(mem.start_write && mem.start_read));

    a_ack_with_stb: assert property (@(posedge clk) disable iff (!reset)
        wb_ack |-> wb_stb);

endmodule

`default_nettype wire

// File: cache/cache_store.sv
`timescale 1ns/10ps
`default_nettype none

module cache_store (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [cache_pkg::index_w-1:0] index,
    input  logic                          wr_en,
    input  logic [cache_pkg::tag_w-1:0]   wr_tag,
    input  logic [cache_pkg::data_w-1:0]  wr_data,
    input  logic                          wr_dirty,
    output logic                          rd_valid,
    output logic                          rd_dirty,
    output logic [cache_pkg::tag_w-1:0]   rd_tag,
    output logic [cache_pkg::data_w-1:0]  rd_data
);

    logic [cache_pkg::tag_w-1:0]  tag_mem  [cache_pkg::lines];
    logic [cache_pkg::data_w-1:0] data_mem [cache_pkg::lines];
    logic [cache_pkg::lines-1:0]  valid_bits;
    logic [cache_pkg::lines-1:0]  dirty_bits;

    // line state flags
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[index]  <= wr_tag;
            data_mem[index] <= wr_data;
        end
    end

    // registered read port, returns the old line on a same-edge write
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_valid <= 1'b0;
            rd_dirty <= 1'b0;
        end else begin
            rd_valid <= valid_bits[index];
            rd_dirty <= dirty_bits[index];
        end
    end

    always_ff @(posedge clk) begin
        rd_tag  <= tag_mem[index];
        rd_data <= data_mem[index];
    end

endmodule

`default_nettype wire

// File: cache_sys.f
common/cache_pkg.sv
common/mem_req_if.sv
cache/cache_store.sv
cache/cache_ctrl.sv
hdl/axi4_master.sv
hdl/cache_top.sv
bench/tb_clock.sv
bench/tb_axi_mem.sv
bench/tb_top.sv

// File: common/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int sel_w  = data_w / 8;

    // address split: tag | index | byte offset
    localparam int off_w    = 2;
    localparam int index_w  = 4;
    localparam int lines    = 1 << index_w;
    localparam int index_lo = off_w;
    localparam int tag_lo   = off_w + index_w;
    localparam int tag_w    = addr_w - tag_lo;

    // cache controller
    typedef enum logic [2:0] {
        c_idle   = 3'b000,
        c_lookup = 3'b001,
        c_evict  = 3'b010,
        c_refill = 3'b011,
        c_ack    = 3'b100
    } ctrl_state_t;

    // axi channel sequencer
    typedef enum logic [2:0] {
        idle  = 3'b000,
        waddr = 3'b001,
        wdata = 3'b010,
        bresp = 3'b011,
        raddr = 3'b100,
        rdata = 3'b101
    } axi_state_t;

endpackage

`default_nettype wire

// File: common/mem_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if;

    // controller side
    logic                         start_write;
    logic                         start_read;
    logic [cache_pkg::addr_w-1:0] addr;
    logic [cache_pkg::data_w-1:0] wdata;

    // axi master side, rdata valid with the axi_ready pulse on reads
    logic [cache_pkg::data_w-1:0] rdata;
    logic                         axi_ready;

    modport ctrl (
        output start_write,
        output start_read,
        output addr,
        output wdata,
        input  rdata,
        input  axi_ready
    );

    modport master (
        input  start_write,
        input  start_read,
        input  addr,
        input  wdata,
        output rdata,
        output axi_ready
    );

endinterface

`default_nettype wire

// File: hdl/axi4_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi4_master (
    input  logic                         clk,
    input  logic                         reset,

    // memory requests from the cache controller
    mem_req_if.master                    mem,

    // axi4 write channels
    output logic                         aw_valid,
    input  logic                         aw_ready,
    output logic [cache_pkg::addr_w-1:0] aw_addr,
    output logic                         w_valid,
    input  logic                         w_ready,
    output logic [cache_pkg::data_w-1:0] w_data,
    input  logic                         b_valid,
    output logic                         b_ready,

    // axi4 read channels
    output logic                         ar_valid,
    input  logic                         ar_ready,
    output logic [cache_pkg::addr_w-1:0] ar_addr,
    input  logic                         r_valid,
    output logic                         r_ready,
    input  logic [cache_pkg::data_w-1:0] r_data
);

    cache_pkg::axi_state_t state, next_state;

    logic [cache_pkg::addr_w-1:0] addr_q;
    logic [cache_pkg::data_w-1:0] wdata_q;
    logic [cache_pkg::data_w-1:0] rdata_q;
    logic                         r_done;
    logic                         b_done;

    assign b_done = (state == cache_pkg::bresp) && b_valid;
    assign r_done = (state == cache_pkg::rdata) && r_valid;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= cache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // read has priority, as in the channel sequencer it came from
    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::idle: begin
                if (mem.start_read) begin
                    next_state = cache_pkg::raddr;
                end else if (mem.start_write) begin
                    next_state = cache_pkg::waddr;
                end
            end
            cache_pkg::waddr: begin
                if (aw_ready) begin
                    next_state = cache_pkg::wdata;
                end
            end
            cache_pkg::wdata: begin
                if (w_ready) begin
                    next_state = cache_pkg::bresp;
                end
            end
            cache_pkg::bresp: begin
                if (b_valid) begin
                    next_state = cache_pkg::idle;
                end
            end
            cache_pkg::raddr: begin
                if (ar_ready) begin
                    next_state = cache_pkg::rdata;
                end
            end
            cache_pkg::rdata: begin
                if (r_valid) begin
                    next_state = cache_pkg::idle;
                end
            end
            default: begin
                next_state = cache_pkg::idle;
            end
        endcase
    end

    // request payload latched when leaving idle
    always_ff @(posedge clk) begin
        if (state == cache_pkg::idle && (mem.start_read || mem.start_write)) begin
            addr_q  <= mem.addr;
            wdata_q <= mem.wdata;
        end
        if (r_done) begin
            rdata_q <= r_data;
        end
    end

    assign aw_valid = (state == cache_pkg::waddr);
    assign w_valid  = (state == cache_pkg::wdata);
    assign b_ready  = (state == cache_pkg::bresp);
    assign ar_valid = (state == cache_pkg::raddr);
    assign r_ready  = (state == cache_pkg::rdata);

    assign aw_addr = addr_q;
    assign ar_addr = addr_q;
    assign w_data  = wdata_q;

    // read word passes through on the handshake, then holds
    assign mem.axi_ready = b_done || r_done;
    assign mem.rdata     = r_done ? r_data : rdata_q;

    a_aw_hold: assert property (@(posedge clk) disable iff (!reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr));

    a_ar_hold: assert property (@(posedge clk) disable iff (!reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

endmodule

`default_nettype wire

// File: hdl/cache_top.sv
`timescale 1ns/10ps
`default_nettype none

module cache_top (
    input  logic                         clk,
    input  logic                         reset,

    // wishbone classic slave
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [cache_pkg::addr_w-1:0] wb_adr,
    input  logic [cache_pkg::data_w-1:0] wb_dat_w,
    input  logic [cache_pkg::sel_w-1:0]  wb_sel,
    output logic [cache_pkg::data_w-1:0] wb_dat_r,
    output logic                         wb_ack,

    // axi4 master
    output logic                         aw_valid,
    input  logic                         aw_ready,
    output logic [cache_pkg::addr_w-1:0] aw_addr,
    output logic                         w_valid,
    input  logic                         w_ready,
    output logic [cache_pkg::data_w-1:0] w_data,
    input  logic                         b_valid,
    output logic                         b_ready,
    output logic                         ar_valid,
    input  logic                         ar_ready,
    output logic [cache_pkg::addr_w-1:0] ar_addr,
    input  logic                         r_valid,
    output logic                         r_ready,
    input  logic [cache_pkg::data_w-1:0] r_data
);

    mem_req_if u_mem_if ();

    logic [cache_pkg::index_w-1:0] index;
    logic                          wr_en;
    logic [cache_pkg::tag_w-1:0]   wr_tag;
    logic [cache_pkg::data_w-1:0]  wr_data;
    logic                          wr_dirty;
    logic                          rd_valid;
    logic                          rd_dirty;
    logic [cache_pkg::tag_w-1:0]   rd_tag;
    logic [cache_pkg::data_w-1:0]  rd_data;

    cache_ctrl u_cache_ctrl (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .mem      (u_mem_if.ctrl),
        .index    (index),
        .wr_en    (wr_en),
        .wr_tag   (wr_tag),
        .wr_data  (wr_data),
        .wr_dirty (wr_dirty),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty),
        .rd_tag   (rd_tag),
        .rd_data  (rd_data)
    );

    cache_store u_cache_store (
        .clk      (clk),
        .reset    (reset),
        .index    (index),
        .wr_en    (wr_en),
        .wr_tag   (wr_tag),
        .wr_data  (wr_data),
        .wr_dirty (wr_dirty),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty),
        .rd_tag   (rd_tag),
        .rd_data  (rd_data)
    );

    axi4_master u_axi4_master (
        .clk      (clk),
        .reset    (reset),
        .mem      (u_mem_if.master),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# compile with verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f cache_sys.f --top-module tb_top -o tb_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
